// ==== project.f ====
+incdir+verif
hdl/fsync_pkg.sv
hdl/fsync_rx.sv
hdl/fsync_arrival_rf.sv
hdl/fsync_rsp_arb.sv
hdl/fsync_apb_regs.sv
hdl/fsync_node.sv
verif/tb_fsync_node.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the fsync node testbench with verilator and runs it.
# exit status is zero only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --assert -f project.f --top-module tb_fsync_node \
  -Mdir "$BUILD_DIR" -o tb_fsync_node
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_fsync_node" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1

// ==== verif/fsync_vectors.svh ====
// ********************
// directed barrier vectors for the node testbench.
// all rows run with the node enabled at level 1.
// ********************

// each row holds first_ws, gap, en id, en mask, ws id, ws mask,
// forwarded, expected id, expected forwarded mask and parent response id.
typedef struct packed {
  logic       first_ws; // ws side arrives first.
  logic [3:0] gap;      // cycles between the two requests.
  logic [3:0] en_id;
  logic [3:0] en_aggr;
  logic [3:0] ws_id;
  logic [3:0] ws_aggr;
  logic       exp_fwd;  // barrier goes up to the parent.
  logic [3:0] exp_id;   // response id, or forwarded id.
  logic [3:0] exp_aggr; // mask of the first arrival.
  logic [3:0] par_id;
} vec_t;

localparam int N_VEC = 7;

vec_t vec_tab [N_VEC] = '{
  // local barriers, both orders and same-cycle arrival.
  '{1'b0, 4'd0, 4'h3, 4'h3, 4'h3, 4'h3, 1'b0, 4'h3, 4'h0, 4'h0},
  '{1'b0, 4'd2, 4'h5, 4'h3, 4'h5, 4'h3, 1'b0, 4'h5, 4'h0, 4'h0},
  '{1'b1, 4'd3, 4'h9, 4'h3, 4'h9, 4'h3, 1'b0, 4'h9, 4'h0, 4'h0},
  '{1'b1, 4'd1, 4'h0, 4'h1, 4'h0, 4'h2, 1'b0, 4'h0, 4'h0, 4'h0},
  // remote barriers.
  '{1'b0, 4'd1, 4'hA, 4'hF, 4'hA, 4'hF, 1'b1, 4'hA, 4'hF, 4'hA},
  '{1'b1, 4'd2, 4'h6, 4'hF, 4'h6, 4'hF, 1'b1, 4'h6, 4'hF, 4'h6},
  '{1'b1, 4'd1, 4'h2, 4'hF, 4'h2, 4'h7, 1'b1, 4'h2, 4'h7, 4'h2} // ws mask travels up.
};

// ==== verif/tb_fsync_node.sv ====
// ********************
// testbench for the barrier sync node.
// register access, table-driven local and remote barriers,
// duplicate and disable cases, then random local barriers.
// ********************

`timescale 1ns/1ps

module tb_fsync_node;

  `include "fsync_vectors.svh"

  localparam int N_RAND         = 8;
  localparam int WINDOW         = 12; // cycles allowed for a response.
  localparam int TIMEOUT_CYCLES = (N_VEC + N_RAND + 10) * 40;

  localparam logic [31:0] CTRL_LVL1 = 32'(1) << fsync_pkg::CTRL_LVL_LSB;
  localparam logic [31:0] CTRL_ON   = CTRL_LVL1 | (32'(1) << fsync_pkg::CTRL_EN_BIT);
  localparam logic [31:0] ST_DUP_EN = 32'(1) << fsync_pkg::ST_RX_EN_BIT;

  logic                         clk_i, rst_ni;
  logic                         req_en_valid_i, req_ws_valid_i;
  logic [fsync_pkg::AGGR_W-1:0] req_en_aggr_i, req_ws_aggr_i, req_out_aggr_o;
  logic [fsync_pkg::ID_W-1:0]   req_en_id_i, req_ws_id_i, rsp_id_o;
  logic [fsync_pkg::ID_W-1:0]   req_out_id_o, rsp_in_id_i;
  logic                         rsp_valid_o, req_out_valid_o, req_out_ready_i, rsp_in_valid_i;
  logic [fsync_pkg::APB_AW-1:0] paddr_i;
  logic                         psel_i, penable_i, pwrite_i, pready_o, pslverr_o;
  logic [fsync_pkg::APB_DW-1:0] pwdata_i, prdata_o;

  int          err_cnt, chk_cnt, exp_count, fwd_cycles, cycle_cnt;
  logic [31:0] rng, rd_data;
  logic        rd_err;
  logic [3:0]  rsp_q [$]; // broadcast ids seen, oldest first.

  fsync_node UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // outputs are taken at the edge before they update.
  always @(posedge clk_i) begin
    if (rsp_valid_o) rsp_q.push_back(rsp_id_o);
    if (req_out_valid_o) fwd_cycles++;
  end

  // ********************
  // helpers.
  // ********************
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic apb_transfer(input logic wr, input logic [fsync_pkg::APB_AW-1:0] addr,
                              input logic [31:0] wdata);
    int waits;
    waits = 0;
    @(posedge clk_i);
    psel_i   <= 1'b1;
    paddr_i  <= addr;
    pwrite_i <= wr;
    pwdata_i <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    while (!pready_o && waits < 4) begin
      waits++;
      @(negedge clk_i);
    end
    if (!pready_o) begin
      err_cnt++;
      $display("apb access to 0x%0h never saw pready at %0t", addr, $time);
    end
    rd_data = prdata_o;
    rd_err  = pslverr_o;
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic read_expect(input logic [fsync_pkg::APB_AW-1:0] addr,
                             input logic [31:0] exp, input string name);
    apb_transfer(1'b0, addr, 32'd0);
    check_value(name, rd_data, exp);
    check_value("pslverr_o", 32'(rd_err), 32'd0);
  endtask

  task automatic drive_req(input logic ws_side, input logic [3:0] id, input logic [3:0] aggr);
    if (ws_side) begin
      req_ws_valid_i <= 1'b1;
      req_ws_id_i    <= id;
      req_ws_aggr_i  <= aggr;
    end else begin
      req_en_valid_i <= 1'b1;
      req_en_id_i    <= id;
      req_en_aggr_i  <= aggr;
    end
  endtask

  task automatic idle_reqs();
    req_en_valid_i <= 1'b0;
    req_ws_valid_i <= 1'b0;
  endtask

  task automatic send_single(input logic ws_side, input logic [3:0] id, input logic [3:0] aggr);
    @(posedge clk_i);
    drive_req(ws_side, id, aggr);
    @(posedge clk_i);
    idle_reqs();
  endtask

  // gap zero puts both requests in the same cycle.
  task automatic send_pair(input logic [3:0] en_id, input logic [3:0] en_aggr,
                           input logic [3:0] ws_id, input logic [3:0] ws_aggr,
                           input logic first_ws, input logic [3:0] gap);
    @(posedge clk_i);
    drive_req(first_ws, first_ws ? ws_id : en_id, first_ws ? ws_aggr : en_aggr);
    repeat (gap) begin
      @(posedge clk_i);
      idle_reqs();
    end
    drive_req(~first_ws, first_ws ? en_id : ws_id, first_ws ? en_aggr : ws_aggr);
    @(posedge clk_i);
    idle_reqs();
  endtask

  task automatic expect_rsp(input logic [3:0] exp_id);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (rsp_q.size() == 0 && n < WINDOW);
    repeat (4) @(negedge clk_i); // a second pulse would land here.
    check_value("response count", 32'(rsp_q.size()), 32'd1);
    if (rsp_q.size() > 0) check_value("rsp_id_o", 32'(rsp_q[0]), 32'(exp_id));
    rsp_q.delete();
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) @(negedge clk_i);
    check_value("response count", 32'(rsp_q.size()), 32'd0);
    check_value("req_out_valid_o cycles", 32'(fwd_cycles), 32'd0);
    rsp_q.delete();
  endtask

  task automatic check_forward(input logic [3:0] exp_id, input logic [3:0] exp_aggr,
                               input logic [3:0] par_id);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!req_out_valid_o && n < WINDOW);
    check_value("req_out_valid_o", 32'(req_out_valid_o), 32'd1);
    check_value("req_out_id_o", 32'(req_out_id_o), 32'(exp_id));
    check_value("req_out_aggr_o", 32'(req_out_aggr_o), 32'(exp_aggr));
    repeat (3) @(negedge clk_i); // parent stalls.
    check_value("req_out_valid_o", 32'(req_out_valid_o), 32'd1);
    check_value("req_out_id_o", 32'(req_out_id_o), 32'(exp_id));
    check_value("response count", 32'(rsp_q.size()), 32'd0);
    @(posedge clk_i);
    req_out_ready_i <= 1'b1;
    @(posedge clk_i);
    req_out_ready_i <= 1'b0;
    @(negedge clk_i);
    check_value("req_out_valid_o", 32'(req_out_valid_o), 32'd0);
    @(posedge clk_i);
    rsp_in_valid_i <= 1'b1;
    rsp_in_id_i    <= par_id;
    @(posedge clk_i);
    rsp_in_valid_i <= 1'b0;
    expect_rsp(par_id);
  endtask

  // ********************
  // sequence.
  // ********************
  initial begin
    vec_t        row;
    logic [3:0]  id;
    logic [15:0] used;
    rst_ni          = 1'b0;
    req_en_valid_i  = 1'b0;
    req_en_aggr_i   = '0;
    req_en_id_i     = '0;
    req_ws_valid_i  = 1'b0;
    req_ws_aggr_i   = '0;
    req_ws_id_i     = '0;
    req_out_ready_i = 1'b0;
    rsp_in_valid_i  = 1'b0;
    rsp_in_id_i     = '0;
    paddr_i         = '0;
    psel_i          = 1'b0;
    penable_i       = 1'b0;
    pwrite_i        = 1'b0;
    pwdata_i        = '0;
    err_cnt         = 0;
    chk_cnt         = 0;
    exp_count       = 0;
    fwd_cycles      = 0;
    rng             = 32'd30175;
    used            = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // register block.
    read_expect(fsync_pkg::ADDR_CTRL, 32'd0, "CTRL");
    read_expect(fsync_pkg::ADDR_STATUS, 32'd0, "STATUS");
    read_expect(fsync_pkg::ADDR_COUNT, 32'd0, "COUNT");
    apb_transfer(1'b1, fsync_pkg::ADDR_CTRL, CTRL_ON);
    read_expect(fsync_pkg::ADDR_CTRL, CTRL_ON, "CTRL");
    apb_transfer(1'b0, 4'hC, 32'd0);
    check_value("pslverr_o", 32'(rd_err), 32'd1);

    // directed table.
    for (int i = 0; i < N_VEC; i++) begin
      row        = vec_tab[i];
      fwd_cycles = 0;
      send_pair(row.en_id, row.en_aggr, row.ws_id, row.ws_aggr, row.first_ws, row.gap);
      if (row.exp_fwd) begin
        check_forward(row.exp_id, row.exp_aggr, row.par_id);
      end else begin
        expect_rsp(row.exp_id);
        check_value("req_out_valid_o cycles", 32'(fwd_cycles), 32'd0);
        exp_count++;
      end
      read_expect(fsync_pkg::ADDR_COUNT, 32'(exp_count), "COUNT");
    end
    fwd_cycles = 0;

    // duplicate arrival on the en side.
    send_single(1'b0, 4'h7, 4'h3);
    expect_quiet(6);
    send_single(1'b0, 4'h7, 4'h3);
    read_expect(fsync_pkg::ADDR_STATUS, ST_DUP_EN, "STATUS");
    apb_transfer(1'b1, fsync_pkg::ADDR_STATUS, ST_DUP_EN);
    read_expect(fsync_pkg::ADDR_STATUS, 32'd0, "STATUS");
    send_single(1'b1, 4'h7, 4'h3);
    expect_rsp(4'h7);
    exp_count++;

    // disabled node ignores both children.
    apb_transfer(1'b1, fsync_pkg::ADDR_CTRL, CTRL_LVL1);
    send_pair(4'h4, 4'h3, 4'h4, 4'h3, 1'b0, 4'd0);
    send_pair(4'h8, 4'hF, 4'h8, 4'hF, 1'b1, 4'd1);
    expect_quiet(10);
    apb_transfer(1'b1, fsync_pkg::ADDR_CTRL, CTRL_ON);

    // random local barriers, distinct ids.
    for (int r = 0; r < N_RAND; r++) begin
      rng = xorshift32(rng);
      id  = rng[3:0];
      while (used[id]) id = id + 1'b1;
      used[id] = 1'b1;
      send_pair(id, {2'b00, rng[5:4]}, id, {2'b00, rng[7:6]}, rng[8], {2'b00, rng[11:10]});
      expect_rsp(id);
      exp_count++;
    end
    read_expect(fsync_pkg::ADDR_COUNT, 32'(exp_count), "COUNT");
    read_expect(fsync_pkg::ADDR_STATUS, 32'd0, "STATUS");

    $display("checks: %0d errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
    $display("checks: %0d errors: %0d", chk_cnt, err_cnt);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== hdl/fsync_node.sv ====
// ********************
// barrier sync tree node.
// two child ports, one parent port and an apb register block.
// ********************

`timescale 1ns/1ps

module fsync_node (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // children.
  input  logic                         req_en_valid_i,
  input  logic [fsync_pkg::AGGR_W-1:0] req_en_aggr_i,
  input  logic [fsync_pkg::ID_W-1:0]   req_en_id_i,
  input  logic                         req_ws_valid_i,
  input  logic [fsync_pkg::AGGR_W-1:0] req_ws_aggr_i,
  input  logic [fsync_pkg::ID_W-1:0]   req_ws_id_i,
  output logic                         rsp_valid_o,
  output logic [fsync_pkg::ID_W-1:0]   rsp_id_o,
  // parent.
  output logic                         req_out_valid_o,
  output logic [fsync_pkg::AGGR_W-1:0] req_out_aggr_o,
  output logic [fsync_pkg::ID_W-1:0]   req_out_id_o,
  input  logic                         req_out_ready_i,
  input  logic                         rsp_in_valid_i,
  input  logic [fsync_pkg::ID_W-1:0]   rsp_in_id_i,
  // apb.
  input  logic [fsync_pkg::APB_AW-1:0] paddr_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [fsync_pkg::APB_DW-1:0] pwdata_i,
  output logic [fsync_pkg::APB_DW-1:0] prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o
);

  logic                         cfg_en;
  logic [fsync_pkg::LVL_W-1:0]  cfg_lvl;
  logic                         en_valid, ws_valid, en_local, ws_local;
  logic [fsync_pkg::AGGR_W-1:0] en_aggr, ws_aggr, match_aggr;
  logic [fsync_pkg::ID_W-1:0]   en_id, ws_id, match_id;
  logic                         match_valid, match_local;
  logic                         dup_en, dup_ws, overflow, local_done;

  // ********************
  // receive and match.
  // ********************
  fsync_rx u_rx_en (
    .clk_i, .rst_ni,
    .req_valid_i (req_en_valid_i), .req_aggr_i (req_en_aggr_i), .req_id_i (req_en_id_i),
    .en_i        (cfg_en),         .lvl_i      (cfg_lvl),
    .valid_o     (en_valid),       .aggr_o     (en_aggr),       .id_o     (en_id),
    .local_o     (en_local)
  );

  fsync_rx u_rx_ws (
    .clk_i, .rst_ni,
    .req_valid_i (req_ws_valid_i), .req_aggr_i (req_ws_aggr_i), .req_id_i (req_ws_id_i),
    .en_i        (cfg_en),         .lvl_i      (cfg_lvl),
    .valid_o     (ws_valid),       .aggr_o     (ws_aggr),       .id_o     (ws_id),
    .local_o     (ws_local)
  );

  fsync_arrival_rf u_arrival_rf (
    .clk_i, .rst_ni,
    .en_valid_i    (en_valid),    .en_aggr_i    (en_aggr),    .en_id_i    (en_id),
    .en_local_i    (en_local),
    .ws_valid_i    (ws_valid),    .ws_aggr_i    (ws_aggr),    .ws_id_i    (ws_id),
    .ws_local_i    (ws_local),
    .match_valid_o (match_valid), .match_id_o   (match_id),   .match_aggr_o (match_aggr),
    .match_local_o (match_local), .dup_en_o     (dup_en),     .dup_ws_o   (dup_ws)
  );

  // ********************
  // respond and forward.
  // ********************
  fsync_rsp_arb u_rsp_arb (
    .clk_i, .rst_ni,
    .match_valid_i   (match_valid),     .match_id_i     (match_id),
    .match_aggr_i    (match_aggr),      .match_local_i  (match_local),
    .req_out_ready_i (req_out_ready_i), .rsp_in_valid_i (rsp_in_valid_i),
    .rsp_in_id_i     (rsp_in_id_i),     .req_out_valid_o (req_out_valid_o),
    .req_out_aggr_o  (req_out_aggr_o),  .req_out_id_o   (req_out_id_o),
    .rsp_valid_o     (rsp_valid_o),     .rsp_id_o       (rsp_id_o),
    .local_done_o    (local_done),      .overflow_o     (overflow)
  );

  fsync_apb_regs u_apb_regs (
    .clk_i, .rst_ni,
    .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .err_rx_en_i  (dup_en),     .err_rx_ws_i (dup_ws), .err_tx_i (overflow),
    .local_done_i (local_done), .cfg_en_o    (cfg_en), .cfg_lvl_o (cfg_lvl)
  );

endmodule

// ==== hdl/fsync_apb_regs.sv ====
// ********************
// node configuration registers on apb.
// ctrl holds enable and level, status collects sticky error flags,
// count tracks completed local barriers. no wait states.
// ********************

`timescale 1ns/1ps

module fsync_apb_regs (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [fsync_pkg::APB_AW-1:0] paddr_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [fsync_pkg::APB_DW-1:0] pwdata_i,
  output logic [fsync_pkg::APB_DW-1:0] prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  input  logic                         err_rx_en_i,
  input  logic                         err_rx_ws_i,
  input  logic                         err_tx_i,
  input  logic                         local_done_i,
  output logic                         cfg_en_o,
  output logic [fsync_pkg::LVL_W-1:0]  cfg_lvl_o
);

  localparam int unsigned ST_W = fsync_pkg::ST_TX_BIT + 1;

  logic                        access, addr_hit;
  logic [ST_W-1:0]             status_q, st_set, st_clr;
  logic [fsync_pkg::CNT_W-1:0] count_q;

  assign access    = psel_i & penable_i;
  assign pready_o  = access;             // never stretched.
  assign pslverr_o = access & ~addr_hit;

  // ********************
  // read path.
  // ********************
  always_comb begin
    prdata_o = '0;
    addr_hit = 1'b1;
    case (paddr_i)
      fsync_pkg::ADDR_CTRL: begin
        prdata_o[fsync_pkg::CTRL_EN_BIT]                     = cfg_en_o;
        prdata_o[fsync_pkg::CTRL_LVL_LSB +: fsync_pkg::LVL_W] = cfg_lvl_o;
      end
      fsync_pkg::ADDR_STATUS: prdata_o[ST_W-1:0] = status_q;
      fsync_pkg::ADDR_COUNT:  prdata_o[fsync_pkg::CNT_W-1:0] = count_q;
      default:                addr_hit = 1'b0;
    endcase
  end

  // ********************
  // write path.
  // ********************
  always_comb begin
    st_set = '0;
    st_set[fsync_pkg::ST_RX_EN_BIT] = err_rx_en_i;
    st_set[fsync_pkg::ST_RX_WS_BIT] = err_rx_ws_i;
    st_set[fsync_pkg::ST_TX_BIT]    = err_tx_i;
    st_clr = '0;
    if (access && pwrite_i && paddr_i == fsync_pkg::ADDR_STATUS) begin
      st_clr = pwdata_i[ST_W-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_en_o  <= 1'b0;
      cfg_lvl_o <= '0;
      status_q  <= '0;
      count_q   <= '0;
    end else begin
      if (access && pwrite_i && paddr_i == fsync_pkg::ADDR_CTRL) begin
        cfg_en_o  <= pwdata_i[fsync_pkg::CTRL_EN_BIT];
        cfg_lvl_o <= pwdata_i[fsync_pkg::CTRL_LVL_LSB +: fsync_pkg::LVL_W];
      end
      status_q <= (status_q & ~st_clr) | st_set; // a new error wins over clear.
      if (local_done_i && count_q != '1) count_q <= count_q + 1'b1; // saturates.
    end
  end

  a_penable_in_sel: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    penable_i |-> psel_i
  ) else $error("fsync_apb_regs: penable without psel.");

endmodule

// ==== hdl/fsync_rsp_arb.sv ====
// ********************
// response arbiter and parent output.
// local matches and parent responses wait in one-entry holding
// registers and share the broadcast port, alternating when both wait.
// ********************

`timescale 1ns/1ps

module fsync_rsp_arb (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         match_valid_i,
  input  logic [fsync_pkg::ID_W-1:0]   match_id_i,
  input  logic [fsync_pkg::AGGR_W-1:0] match_aggr_i,
  input  logic                         match_local_i,
  input  logic                         req_out_ready_i,
  input  logic                         rsp_in_valid_i,
  input  logic [fsync_pkg::ID_W-1:0]   rsp_in_id_i,
  output logic                         req_out_valid_o,
  output logic [fsync_pkg::AGGR_W-1:0] req_out_aggr_o,
  output logic [fsync_pkg::ID_W-1:0]   req_out_id_o,
  output logic                         rsp_valid_o,
  output logic [fsync_pkg::ID_W-1:0]   rsp_id_o,
  output logic                         local_done_o,
  output logic                         overflow_o
);

  logic loc_v_q, par_v_q, prio_q;
  logic [fsync_pkg::ID_W-1:0] loc_id_q, par_id_q;
  logic loc_in, rem_in, sel_par, loc_load, par_load, rem_load;

  assign loc_in  = match_valid_i & match_local_i;
  assign rem_in  = match_valid_i & ~match_local_i;
  assign sel_par = par_v_q & (~loc_v_q | prio_q); // prio_q set means parent first.

  // a holding register refills in the cycle it is sent.
  assign loc_load = loc_in & (~loc_v_q | ~sel_par);
  assign par_load = rsp_in_valid_i & (~par_v_q | sel_par);
  assign rem_load = rem_in & (~req_out_valid_o | req_out_ready_i);

  assign rsp_valid_o  = loc_v_q | par_v_q;
  assign rsp_id_o     = sel_par ? par_id_q : loc_id_q;
  assign local_done_o = loc_v_q & ~sel_par;
  assign overflow_o   = (loc_in & ~loc_load) | (rsp_in_valid_i & ~par_load)
                      | (rem_in & ~rem_load);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loc_v_q         <= 1'b0;
      par_v_q         <= 1'b0;
      prio_q          <= 1'b0;
      req_out_valid_o <= 1'b0;
    end else begin
      loc_v_q <= loc_load | (loc_v_q & sel_par);
      par_v_q <= par_load | (par_v_q & ~sel_par);
      if (loc_v_q && par_v_q) prio_q <= ~prio_q;
      req_out_valid_o <= rem_load | (req_out_valid_o & ~req_out_ready_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (loc_load) loc_id_q <= match_id_i;
    if (par_load) par_id_q <= rsp_in_id_i;
    if (rem_load) begin
      req_out_id_o   <= match_id_i;
      req_out_aggr_o <= match_aggr_i;
    end
  end

  a_req_out_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_out_valid_o && !req_out_ready_i
      |=> req_out_valid_o && $stable(req_out_id_o) && $stable(req_out_aggr_o)
  ) else $error("fsync_rsp_arb: parent request changed while stalled.");

endmodule

// ==== hdl/fsync_arrival_rf.sv ====
// ********************
// arrival table.
// two arrival bits per barrier id. a request whose opposite bit
// is set, or a same-id pair, completes a barrier.
// ********************

`timescale 1ns/1ps

module fsync_arrival_rf (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         en_valid_i,
  input  logic [fsync_pkg::AGGR_W-1:0] en_aggr_i,
  input  logic [fsync_pkg::ID_W-1:0]   en_id_i,
  input  logic                         en_local_i,
  input  logic                         ws_valid_i,
  input  logic [fsync_pkg::AGGR_W-1:0] ws_aggr_i,
  input  logic [fsync_pkg::ID_W-1:0]   ws_id_i,
  input  logic                         ws_local_i,
  output logic                         match_valid_o,
  output logic [fsync_pkg::ID_W-1:0]   match_id_o,
  output logic [fsync_pkg::AGGR_W-1:0] match_aggr_o,
  output logic                         match_local_o,
  output logic                         dup_en_o,
  output logic                         dup_ws_o
);

  logic [fsync_pkg::N_IDS-1:0]  arr_en_q, arr_ws_q;
  logic [fsync_pkg::AGGR_W-1:0] aggr_q [fsync_pkg::N_IDS];
  logic [fsync_pkg::N_IDS-1:0]  local_q;

  logic en_hit, ws_hit, pair, en_first, ws_first, ws_defer;
  logic left_valid;
  logic [fsync_pkg::ID_W-1:0] left_id;

  // ********************
  // match detection.
  // ********************
  assign dup_en_o = en_valid_i & arr_en_q[en_id_i];
  assign dup_ws_o = ws_valid_i & arr_ws_q[ws_id_i];
  assign en_hit   = en_valid_i & ~dup_en_o & arr_ws_q[en_id_i];
  assign ws_hit   = ws_valid_i & ~dup_ws_o & arr_en_q[ws_id_i];
  assign pair     = en_valid_i & ws_valid_i & (en_id_i == ws_id_i)
                  & ~arr_en_q[en_id_i] & ~arr_ws_q[en_id_i];
  assign en_first = en_valid_i & ~dup_en_o & ~en_hit & ~pair;
  assign ws_first = ws_valid_i & ~dup_ws_o & ~ws_hit & ~pair;
  assign ws_defer = en_hit & ws_hit; // second match parks with both bits set.

  // parked barriers leave in idle cycles with the lowest id first.
  always_comb begin
    left_valid = 1'b0;
    left_id    = '0;
    for (int i = fsync_pkg::N_IDS - 1; i >= 0; i--) begin
      if (arr_en_q[i] && arr_ws_q[i]) begin
        left_valid = 1'b1;
        left_id    = i[fsync_pkg::ID_W-1:0];
      end
    end
  end

  always_comb begin
    match_valid_o = pair | en_hit | ws_hit | left_valid;
    if (pair || en_hit) match_id_o = en_id_i;
    else if (ws_hit)    match_id_o = ws_id_i;
    else                match_id_o = left_id;
    // keep the mask of the first arrival.
    match_aggr_o  = pair ? en_aggr_i  : aggr_q[match_id_o];
    match_local_o = pair ? en_local_i : local_q[match_id_o];
  end

  // ********************
  // table update.
  // ********************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arr_en_q <= '0;
      arr_ws_q <= '0;
    end else begin
      if (en_first) arr_en_q[en_id_i] <= 1'b1;
      if (ws_first || ws_defer) arr_ws_q[ws_id_i] <= 1'b1;
      if (match_valid_o) begin
        arr_en_q[match_id_o] <= 1'b0;
        arr_ws_q[match_id_o] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_first) begin
      aggr_q[en_id_i]  <= en_aggr_i;
      local_q[en_id_i] <= en_local_i;
    end
    if (ws_first) begin
      aggr_q[ws_id_i]  <= ws_aggr_i;
      local_q[ws_id_i] <= ws_local_i;
    end
  end

  // a match on an empty entry needs both sides in the same cycle.
  a_match_has_arrival: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    match_valid_o && !arr_en_q[match_id_o] && !arr_ws_q[match_id_o]
      |-> en_valid_i && ws_valid_i && en_id_i == ws_id_i
  ) else $error("fsync_arrival_rf: match without arrival.");

endmodule

// ==== hdl/fsync_rx.sv ====
// ********************
// child request receiver.
// samples one request pulse per cycle, drops it while the node
// is disabled and tags it local or remote against the level.
// ********************

`timescale 1ns/1ps

module fsync_rx (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_valid_i,
  input  logic [fsync_pkg::AGGR_W-1:0] req_aggr_i,
  input  logic [fsync_pkg::ID_W-1:0]  req_id_i,
  input  logic                        en_i,
  input  logic [fsync_pkg::LVL_W-1:0] lvl_i,
  output logic                        valid_o,
  output logic [fsync_pkg::AGGR_W-1:0] aggr_o,
  output logic [fsync_pkg::ID_W-1:0]  id_o,
  output logic                        local_o
);

  logic is_local;

  // local when no mask bit above the node level is set.
  always_comb begin
    is_local = 1'b1;
    for (int i = 0; i < fsync_pkg::AGGR_W; i++) begin
      if (i > int'(lvl_i) && req_aggr_i[i]) is_local = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= req_valid_i & en_i; // disabled node ignores children.
    end
  end

  // payload loads with each request.
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      aggr_o  <= req_aggr_i;
      id_o    <= req_id_i;
      local_o <= is_local;
    end
  end

  a_req_id_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> !$isunknown(req_id_i)
  ) else $error("fsync_rx: unknown id on a valid request.");

endmodule

// ==== hdl/fsync_pkg.sv ====
// ********************
// barrier sync node package.
// widths, register map and field positions shared by the node
// and its configuration block.
// ********************

package fsync_pkg;

  // ********************
  // request and response fields.
  // ********************
  localparam int unsigned AGGR_W = 4;  // aggregate mask.
  localparam int unsigned ID_W   = 4;  // barrier id.
  localparam int unsigned N_IDS  = 16; // one arrival entry per id.
  localparam int unsigned LVL_W  = 2;  // node level.
  localparam int unsigned CNT_W  = 16; // local barrier counter.

  // ********************
  // apb register map.
  // ********************
  localparam int unsigned APB_AW = 4;
  localparam int unsigned APB_DW = 32;

  localparam logic [APB_AW-1:0] ADDR_CTRL   = 4'h0;
  localparam logic [APB_AW-1:0] ADDR_STATUS = 4'h4;
  localparam logic [APB_AW-1:0] ADDR_COUNT  = 4'h8;

  // ctrl fields.
  localparam int unsigned CTRL_EN_BIT  = 0;
  localparam int unsigned CTRL_LVL_LSB = 4;

  // sticky status flags that clear when written with one.
  localparam int unsigned ST_RX_EN_BIT = 0;
  localparam int unsigned ST_RX_WS_BIT = 1;
  localparam int unsigned ST_TX_BIT    = 2;

endpackage
